/* hdl/rv_core_pkg.sv */
// Core package: opcodes, ALU operations, instruction formats, reset PC and response codes.
`default_nettype none

package rv_core_pkg;

	localparam int XLEN = 32;

	// First fetch address after reset.
	localparam logic [XLEN-1:0] RESET_PC = 32'h0;

	// Read response code, the only one the memory returns.
	localparam logic [1:0] RESP_OKAY = 2'b00;

	typedef enum logic [6:0] {
		OPC_OP     = 7'b0110011,
		OPC_OP_IMM = 7'b0010011,
		OPC_LUI    = 7'b0110111,
		OPC_BRANCH = 7'b1100011,
		OPC_JAL    = 7'b1101111
	} opcode_e;

	typedef enum logic [2:0] {
		ALU_ADD,
		ALU_SUB,
		ALU_AND,
		ALU_OR,
		ALU_XOR,
		ALU_PASS_B
	} alu_op_e;

	// Field layouts, most significant field first.
	typedef struct packed {
		logic [6:0] funct7;
		logic [4:0] rs2;
		logic [4:0] rs1;
		logic [2:0] funct3;
		logic [4:0] rd;
		opcode_e    opcode;
	} r_fmt_t;

	typedef struct packed {
		logic [11:0] imm;
		logic [4:0]  rs1;
		logic [2:0]  funct3;
		logic [4:0]  rd;
		opcode_e     opcode;
	} i_fmt_t;

	typedef struct packed {
		logic       imm12;
		logic [5:0] imm10_5;
		logic [4:0] rs2;
		logic [4:0] rs1;
		logic [2:0] funct3;
		logic [3:0] imm4_1;
		logic       imm11;
		opcode_e    opcode;
	} b_fmt_t;

	typedef struct packed {
		logic [19:0] imm;
		logic [4:0]  rd;
		opcode_e     opcode;
	} u_fmt_t;

	typedef struct packed {
		logic       imm20;
		logic [9:0] imm10_1;
		logic       imm11;
		logic [7:0] imm19_12;
		logic [4:0] rd;
		opcode_e    opcode;
	} j_fmt_t;

	// One instruction word, seen through any of its formats.
	typedef union packed {
		r_fmt_t r;
		i_fmt_t i;
		b_fmt_t b;
		u_fmt_t u;
		j_fmt_t j;
	} inst_u;

endpackage

`default_nettype wire

/* hdl/rv_fetch.sv */
// Instruction fetch: next-PC selection, PC register and read-channel FSM.
`timescale 1ns/1ps
`default_nettype none

module rv_fetch import rv_core_pkg::*; #(
	parameter int IMEM_DEPTH = 256
) (
	input  logic            clk,
	input  logic            rst,
	output logic [XLEN-1:0] araddr,
	output logic            arvalid,
	input  logic            arready,
	input  logic [XLEN-1:0] rdata,
	input  logic            rvalid,
	input  logic [1:0]      rresp,
	output logic            rready,
	output logic            fetch_valid,
	output logic [XLEN-1:0] fetch_inst,
	output logic [XLEN-1:0] fetch_pc,
	input  logic            dec_valid,
	input  logic            exe_valid,
	input  logic            retire_valid,
	input  logic            redirect_taken,
	input  logic [XLEN-1:0] redirect_pc
);

	localparam logic [2:0] S_IDLE      = 3'd0;
	localparam logic [2:0] S_WAIT_AR   = 3'd1;
	localparam logic [2:0] S_SHAKED_AR = 3'd2;
	localparam logic [2:0] S_WAIT_R    = 3'd3;
	localparam logic [2:0] S_SHAKED_R  = 3'd4;

	logic [2:0]      state;
	logic [2:0]      next_state;
	logic [XLEN-1:0] pc_q;
	logic [XLEN-1:0] next_pc;
	logic            redir_taken_q;
	logic [XLEN-1:0] redir_pc_q;
	logic            word_held;
	logic            allowin;

	// Held word is released in the cycle it retires.
	assign allowin = !dec_valid && !exe_valid && (!word_held || retire_valid);

	// Reset leaves a pending redirect to RESET_PC.
	assign next_pc = redir_taken_q ? redir_pc_q : pc_q + XLEN'(4);

	always_comb begin
		next_state = state;
		case (state)
			S_IDLE:      next_state = allowin ? S_WAIT_AR : S_IDLE;
			S_WAIT_AR:   next_state = arready ? S_SHAKED_AR : S_WAIT_AR;
			S_SHAKED_AR: next_state = rvalid ? S_SHAKED_R : S_WAIT_R;
			S_WAIT_R:    next_state = rvalid ? S_SHAKED_R : S_WAIT_R;
			S_SHAKED_R:  next_state = allowin ? S_WAIT_AR : S_IDLE;
			default:     next_state = S_IDLE;
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			state     <= S_IDLE;
			arvalid   <= 1'b0;
			rready    <= 1'b0;
			word_held <= 1'b0;
		end else begin
			state   <= next_state;
			arvalid <= next_state == S_WAIT_AR;
			rready  <= next_state == S_SHAKED_AR || next_state == S_WAIT_R;
			if (fetch_valid)
				word_held <= 1'b1;
			else if (retire_valid)
				word_held <= 1'b0;
		end
	end

	// Address is loaded only when a new request starts.
	always_ff @(posedge clk) begin
		if (state != S_WAIT_AR && next_state == S_WAIT_AR)
			araddr <= next_pc;
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			pc_q          <= RESET_PC;
			redir_taken_q <= 1'b1;
			redir_pc_q    <= RESET_PC;
		end else begin
			if (arvalid && arready)
				pc_q <= araddr;
			if (exe_valid) begin
				redir_taken_q <= redirect_taken;
				redir_pc_q    <= redirect_pc;
			end
		end
	end

	// Word goes downstream in the data handshake cycle.
	assign fetch_valid = rvalid && rready;
	assign fetch_inst  = rdata;
	assign fetch_pc    = pc_q;

	a_ar_hold: assert property (@(posedge clk) disable iff (rst)
		arvalid && !arready |=> arvalid && $stable(araddr));

	a_ar_range: assert property (@(posedge clk) disable iff (rst)
		arvalid |-> araddr[1:0] == 2'b00 && araddr < XLEN'(IMEM_DEPTH * 4));

	a_resp_okay: assert property (@(posedge clk) disable iff (rst)
		rvalid && rready |-> rresp == RESP_OKAY);

endmodule

`default_nettype wire

/* hdl/rv_decode.sv */
// Decode stage: format split, immediates, ALU controls and register reads.
`timescale 1ns/1ps
`default_nettype none

module rv_decode import rv_core_pkg::*; (
	input  logic            clk,
	input  logic            rst,
	input  logic            fetch_valid,
	input  logic [XLEN-1:0] fetch_inst,
	input  logic [XLEN-1:0] fetch_pc,
	input  logic [XLEN-1:0] rs1_data,
	input  logic [XLEN-1:0] rs2_data,
	output logic [4:0]      rs1_addr,
	output logic [4:0]      rs2_addr,
	output logic            dec_valid,
	output logic [XLEN-1:0] dec_pc,
	output logic [4:0]      dec_rd,
	output logic            dec_we,
	output alu_op_e         dec_alu_op,
	output logic [XLEN-1:0] dec_a,
	output logic [XLEN-1:0] dec_b,
	output logic [XLEN-1:0] dec_rs2_val,
	output logic            dec_branch,
	output logic            dec_bne,
	output logic            dec_jal,
	output logic [XLEN-1:0] dec_imm
);

	inst_u           inst;
	logic [XLEN-1:0] imm;
	alu_op_e         alu_op;
	logic            we;
	logic            supported;

	assign inst     = fetch_inst;
	assign rs1_addr = inst.r.rs1;
	assign rs2_addr = inst.r.rs2;

	always_comb begin
		imm    = '0;
		alu_op = ALU_ADD;
		we     = 1'b0;
		case (inst.r.opcode)
			OPC_OP: begin
				we = 1'b1;
				case (inst.r.funct3)
					3'b100:  alu_op = ALU_XOR;
					3'b110:  alu_op = ALU_OR;
					3'b111:  alu_op = ALU_AND;
					default: alu_op = inst.r.funct7[5] ? ALU_SUB : ALU_ADD;
				endcase
			end
			OPC_OP_IMM: begin
				we  = 1'b1;
				imm = {{20{inst.i.imm[11]}}, inst.i.imm};
			end
			OPC_LUI: begin
				we     = 1'b1;
				alu_op = ALU_PASS_B;
				imm    = {inst.u.imm, 12'b0};
			end
			// Branch and jump offsets are even by encoding.
			OPC_BRANCH: imm = {{19{inst.b.imm12}}, inst.b.imm12, inst.b.imm11,
				inst.b.imm10_5, inst.b.imm4_1, 1'b0};
			OPC_JAL: begin
				we  = 1'b1;
				imm = {{11{inst.j.imm20}}, inst.j.imm20, inst.j.imm19_12, inst.j.imm11,
					inst.j.imm10_1, 1'b0};
			end
			default: ;
		endcase
	end

	always_comb begin
		case (inst.r.opcode)
			OPC_OP: supported = (inst.r.funct7 == 7'b0000000 &&
				inst.r.funct3 inside {3'b000, 3'b100, 3'b110, 3'b111}) ||
				(inst.r.funct7 == 7'b0100000 && inst.r.funct3 == 3'b000);
			OPC_OP_IMM:       supported = inst.i.funct3 == 3'b000;
			OPC_BRANCH:       supported = inst.b.funct3[2:1] == 2'b00;
			OPC_LUI, OPC_JAL: supported = 1'b1;
			default:          supported = 1'b0;
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst)
			dec_valid <= 1'b0;
		else
			dec_valid <= fetch_valid;
	end

	always_ff @(posedge clk) begin
		if (fetch_valid) begin
			dec_pc      <= fetch_pc;
			dec_rd      <= inst.r.rd;
			dec_we      <= we;
			dec_alu_op  <= alu_op;
			dec_a       <= rs1_data;
			dec_b       <= (inst.r.opcode == OPC_OP) ? rs2_data : imm;
			dec_rs2_val <= rs2_data;
			dec_branch  <= inst.r.opcode == OPC_BRANCH;
			dec_bne     <= inst.b.funct3[0];
			dec_jal     <= inst.r.opcode == OPC_JAL;
			dec_imm     <= imm;
		end
	end

	a_supported: assert property (@(posedge clk) disable iff (rst)
		fetch_valid |-> supported);

endmodule

`default_nettype wire

/* hdl/rv_execute.sv */
// Execute stage: ALU, branch compare and redirect target.
`timescale 1ns/1ps
`default_nettype none

module rv_execute import rv_core_pkg::*; (
	input  logic            clk,
	input  logic            rst,
	input  logic            dec_valid,
	input  logic [XLEN-1:0] dec_pc,
	input  logic [4:0]      dec_rd,
	input  logic            dec_we,
	input  alu_op_e         dec_alu_op,
	input  logic [XLEN-1:0] dec_a,
	input  logic [XLEN-1:0] dec_b,
	input  logic [XLEN-1:0] dec_rs2_val,
	input  logic            dec_branch,
	input  logic            dec_bne,
	input  logic            dec_jal,
	input  logic [XLEN-1:0] dec_imm,
	output logic            exe_valid,
	output logic [XLEN-1:0] exe_pc,
	output logic [4:0]      exe_rd,
	output logic            exe_we,
	output logic [XLEN-1:0] exe_wdata,
	output logic            redirect_taken,
	output logic [XLEN-1:0] redirect_pc
);

	logic [XLEN-1:0] alu_res;
	logic [XLEN-1:0] wdata;
	logic            br_taken;

	always_comb begin
		case (dec_alu_op)
			ALU_SUB:    alu_res = dec_a - dec_b;
			ALU_AND:    alu_res = dec_a & dec_b;
			ALU_OR:     alu_res = dec_a | dec_b;
			ALU_XOR:    alu_res = dec_a ^ dec_b;
			ALU_PASS_B: alu_res = dec_b;
			default:    alu_res = dec_a + dec_b;
		endcase
	end

	// Link value for JAL.
	assign wdata = dec_jal ? dec_pc + XLEN'(4) : alu_res;

	// BNE inverts the equality result.
	assign br_taken = dec_branch && ((dec_a == dec_rs2_val) != dec_bne);

	always_ff @(posedge clk) begin
		if (rst) begin
			exe_valid      <= 1'b0;
			redirect_taken <= 1'b0;
		end else begin
			exe_valid <= dec_valid;
			if (dec_valid)
				redirect_taken <= br_taken || dec_jal;
		end
	end

	always_ff @(posedge clk) begin
		if (dec_valid) begin
			exe_pc      <= dec_pc;
			exe_rd      <= dec_we ? dec_rd : 5'd0;
			exe_we      <= dec_we;
			exe_wdata   <= wdata;
			redirect_pc <= dec_pc + dec_imm;
		end
	end

	a_target_aligned: assert property (@(posedge clk) disable iff (rst)
		exe_valid && redirect_taken |-> redirect_pc[1:0] == 2'b00);

endmodule

`default_nettype wire

/* hdl/rv_result.sv */
// Register file with two read ports and one write port, plus retire outputs.
`timescale 1ns/1ps
`default_nettype none

module rv_result import rv_core_pkg::*; (
	input  logic            clk,
	input  logic            rst,
	input  logic [4:0]      rs1_addr,
	input  logic [4:0]      rs2_addr,
	output logic [XLEN-1:0] rs1_data,
	output logic [XLEN-1:0] rs2_data,
	input  logic            exe_valid,
	input  logic [XLEN-1:0] exe_pc,
	input  logic [4:0]      exe_rd,
	input  logic            exe_we,
	input  logic [XLEN-1:0] exe_wdata,
	output logic            retire_valid,
	output logic [XLEN-1:0] retire_pc,
	output logic [4:0]      retire_rd,
	output logic [XLEN-1:0] retire_wdata
);

	// Entry 0 is never written.
	logic [XLEN-1:0] regs [32];

	assign rs1_data = (rs1_addr == 5'd0) ? '0 : regs[rs1_addr];
	assign rs2_data = (rs2_addr == 5'd0) ? '0 : regs[rs2_addr];

	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < 32; i++)
				regs[i] <= '0;
		end else if (exe_valid && exe_we && exe_rd != 5'd0) begin
			regs[exe_rd] <= exe_wdata;
		end
	end

	always_ff @(posedge clk) begin
		if (rst)
			retire_valid <= 1'b0;
		else
			retire_valid <= exe_valid;
	end

	always_ff @(posedge clk) begin
		if (exe_valid) begin
			retire_pc    <= exe_pc;
			retire_rd    <= exe_rd;
			retire_wdata <= (exe_rd == 5'd0) ? '0 : exe_wdata;
		end
	end

	a_retire_gap: assert property (@(posedge clk) disable iff (rst)
		retire_valid |=> !retire_valid);

endmodule

`default_nettype wire

/* hdl/rv_imem.sv */
// Instruction memory with load port and random wait states on both read channels.
`timescale 1ns/1ps
`default_nettype none

module rv_imem import rv_core_pkg::*; #(
	parameter int          IMEM_DEPTH = 256,
	parameter logic [15:0] WAIT_SEED  = 16'hace1
) (
	input  logic                          clk,
	input  logic                          rst,
	input  logic                          load_en,
	input  logic [$clog2(IMEM_DEPTH)-1:0] load_addr,
	input  logic [XLEN-1:0]               load_data,
	input  logic [XLEN-1:0]               araddr,
	input  logic                          arvalid,
	output logic                          arready,
	output logic [XLEN-1:0]               rdata,
	output logic                          rvalid,
	output logic [1:0]                    rresp,
	input  logic                          rready
);

	localparam int AW = $clog2(IMEM_DEPTH);

	logic [XLEN-1:0] mem [IMEM_DEPTH];
	logic [15:0]     lfsr;
	logic            r_phase;
	logic [1:0]      wait_cnt;

	assign arready = !r_phase && wait_cnt == 2'd0;
	assign rvalid  = r_phase && wait_cnt == 2'd0;
	assign rresp   = RESP_OKAY;

	always_ff @(posedge clk) begin
		if (rst) begin
			lfsr     <= WAIT_SEED;
			r_phase  <= 1'b0;
			wait_cnt <= WAIT_SEED[1:0];
		end else begin
			lfsr <= {lfsr[14:0], lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10]};
			if (!r_phase) begin
				// Address wait only counts while a request is pending.
				if (arvalid && arready) begin
					r_phase  <= 1'b1;
					wait_cnt <= lfsr[1:0];
				end else if (arvalid && wait_cnt != 2'd0) begin
					wait_cnt <= wait_cnt - 2'd1;
				end
			end else if (rvalid && rready) begin
				r_phase  <= 1'b0;
				wait_cnt <= lfsr[1:0];
			end else if (wait_cnt != 2'd0) begin
				wait_cnt <= wait_cnt - 2'd1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (load_en)
			mem[load_addr] <= load_data;
		if (arvalid && arready)
			rdata <= mem[araddr[AW+1:2]];
	end

	a_no_load_in_fetch: assert property (@(posedge clk) disable iff (rst)
		!(load_en && arvalid));

endmodule

`default_nettype wire

/* hdl/rv_core_top.sv */
// Core top level: fetch, decode, execute, result and instruction memory.
`timescale 1ns/1ps
`default_nettype none

module rv_core_top import rv_core_pkg::*; #(
	parameter int          IMEM_DEPTH = 256,
	parameter logic [15:0] WAIT_SEED  = 16'hace1
) (
	input  logic                          clk,
	input  logic                          rst,
	input  logic                          load_en,
	input  logic [$clog2(IMEM_DEPTH)-1:0] load_addr,
	input  logic [XLEN-1:0]               load_data,
	output logic                          retire_valid,
	output logic [XLEN-1:0]               retire_pc,
	output logic [4:0]                    retire_rd,
	output logic [XLEN-1:0]               retire_wdata
);

	logic [XLEN-1:0] araddr;
	logic            arvalid;
	logic            arready;
	logic [XLEN-1:0] rdata;
	logic            rvalid;
	logic [1:0]      rresp;
	logic            rready;
	logic            fetch_valid;
	logic [XLEN-1:0] fetch_inst;
	logic [XLEN-1:0] fetch_pc;
	logic [4:0]      rs1_addr;
	logic [4:0]      rs2_addr;
	logic [XLEN-1:0] rs1_data;
	logic [XLEN-1:0] rs2_data;
	logic            dec_valid;
	logic [XLEN-1:0] dec_pc;
	logic [4:0]      dec_rd;
	logic            dec_we;
	alu_op_e         dec_alu_op;
	logic [XLEN-1:0] dec_a;
	logic [XLEN-1:0] dec_b;
	logic [XLEN-1:0] dec_rs2_val;
	logic            dec_branch;
	logic            dec_bne;
	logic            dec_jal;
	logic [XLEN-1:0] dec_imm;
	logic            exe_valid;
	logic [XLEN-1:0] exe_pc;
	logic [4:0]      exe_rd;
	logic            exe_we;
	logic [XLEN-1:0] exe_wdata;
	logic            redirect_taken;
	logic [XLEN-1:0] redirect_pc;

	rv_fetch #(.IMEM_DEPTH(IMEM_DEPTH)) u_rv_fetch (
		.clk, .rst, .araddr, .arvalid, .arready, .rdata, .rvalid, .rresp, .rready,
		.fetch_valid, .fetch_inst, .fetch_pc, .dec_valid, .exe_valid, .retire_valid,
		.redirect_taken, .redirect_pc
	);

	rv_decode u_rv_decode (
		.clk, .rst, .fetch_valid, .fetch_inst, .fetch_pc, .rs1_data, .rs2_data,
		.rs1_addr, .rs2_addr, .dec_valid, .dec_pc, .dec_rd, .dec_we, .dec_alu_op,
		.dec_a, .dec_b, .dec_rs2_val, .dec_branch, .dec_bne, .dec_jal, .dec_imm
	);

	rv_execute u_rv_execute (
		.clk, .rst, .dec_valid, .dec_pc, .dec_rd, .dec_we, .dec_alu_op, .dec_a, .dec_b,
		.dec_rs2_val, .dec_branch, .dec_bne, .dec_jal, .dec_imm, .exe_valid, .exe_pc,
		.exe_rd, .exe_we, .exe_wdata, .redirect_taken, .redirect_pc
	);

	rv_result u_rv_result (
		.clk, .rst, .rs1_addr, .rs2_addr, .rs1_data, .rs2_data, .exe_valid, .exe_pc,
		.exe_rd, .exe_we, .exe_wdata, .retire_valid, .retire_pc, .retire_rd, .retire_wdata
	);

	rv_imem #(.IMEM_DEPTH(IMEM_DEPTH), .WAIT_SEED(WAIT_SEED)) u_rv_imem (
		.clk, .rst, .load_en, .load_addr, .load_data, .araddr, .arvalid, .arready,
		.rdata, .rvalid, .rresp, .rready
	);

endmodule

`default_nettype wire

/* include/rv_core_ref.svh */
// Reference model: executes one instruction on a model register file.
`ifndef RV_CORE_REF_SVH
`define RV_CORE_REF_SVH

// Returns the expected retire values and advances pc and regs.
function automatic void rv_ref_step(
	input  logic [31:0] word,
	inout  logic [31:0] pc,
	inout  logic [31:0] regs [32],
	output logic [31:0] exp_pc,
	output logic [4:0]  exp_rd,
	output logic [31:0] exp_wdata
);
	rv_core_pkg::inst_u inst;
	logic [31:0]        a;
	logic [31:0]        b;
	logic [31:0]        wdata;
	logic [31:0]        next_pc;
	logic               we;

	inst    = word;
	a       = regs[inst.r.rs1];
	b       = regs[inst.r.rs2];
	wdata   = '0;
	next_pc = pc + 32'd4;
	we      = 1'b1;
	case (inst.r.opcode)
		rv_core_pkg::OPC_OP: begin
			case (inst.r.funct3)
				3'b100:  wdata = a ^ b;
				3'b110:  wdata = a | b;
				3'b111:  wdata = a & b;
				default: wdata = inst.r.funct7[5] ? a - b : a + b;
			endcase
		end
		rv_core_pkg::OPC_OP_IMM: wdata = a + {{20{inst.i.imm[11]}}, inst.i.imm};
		rv_core_pkg::OPC_LUI:    wdata = {inst.u.imm, 12'b0};
		rv_core_pkg::OPC_BRANCH: begin
			we = 1'b0;
			if ((a == b) != inst.b.funct3[0])
				next_pc = pc + {{19{inst.b.imm12}}, inst.b.imm12, inst.b.imm11,
					inst.b.imm10_5, inst.b.imm4_1, 1'b0};
		end
		rv_core_pkg::OPC_JAL: begin
			wdata   = pc + 32'd4;
			next_pc = pc + {{11{inst.j.imm20}}, inst.j.imm20, inst.j.imm19_12,
				inst.j.imm11, inst.j.imm10_1, 1'b0};
		end
		default: we = 1'b0;
	endcase
	exp_pc    = pc;
	exp_rd    = we ? inst.r.rd : 5'd0;
	exp_wdata = (exp_rd == 5'd0) ? 32'd0 : wdata;
	if (exp_rd != 5'd0)
		regs[exp_rd] = wdata;
	pc = next_pc;
endfunction

`endif

/* bench/rv_core_tb.sv */
// Testbench for the RV32I core: clock, reset, random program, memory load and retire checks.
`timescale 1ns/1ps
`default_nettype none

module rv_core_tb;

	localparam int          IMEM_DEPTH     = 256;
	localparam logic [15:0] WAIT_SEED      = 16'hace1;
	localparam int          PROG_LEN       = 64;
	localparam int          NUM_RETIRE     = 200;
	localparam int          RETIRE_TIMEOUT = 64;
	localparam int          RESET_TIMEOUT  = 500;

	logic                          clk = 1'b0;
	logic                          rst;
	logic                          load_en;
	logic [$clog2(IMEM_DEPTH)-1:0] load_addr;
	logic [31:0]                   load_data;
	logic                          retire_valid;
	logic [31:0]                   retire_pc;
	logic [4:0]                    retire_rd;
	logic [31:0]                   retire_wdata;

	logic [31:0] prog [PROG_LEN];

	`include "rv_core_ref.svh"

	rv_core_top #(.IMEM_DEPTH(IMEM_DEPTH), .WAIT_SEED(WAIT_SEED)) u_rv_core_top (
		.clk, .rst, .load_en, .load_addr, .load_data,
		.retire_valid, .retire_pc, .retire_rd, .retire_wdata
	);

	always #2 clk = ~clk;

	task automatic stop_with_failure(input string reason);
		$display("%s", reason);
		$display("SIMULATION FAILED");
		$fatal(1);
	endtask

	// Instruction encoders, written from the RV32I field layouts.
	function automatic logic [31:0] enc_r(input logic [6:0] funct7, input logic [4:0] rs2,
		input logic [4:0] rs1, input logic [2:0] funct3, input logic [4:0] rd);
		return {funct7, rs2, rs1, funct3, rd, 7'b0110011};
	endfunction

	function automatic logic [31:0] enc_addi(input logic [11:0] imm, input logic [4:0] rs1,
		input logic [4:0] rd);
		return {imm, rs1, 3'b000, rd, 7'b0010011};
	endfunction

	function automatic logic [31:0] enc_lui(input logic [19:0] imm, input logic [4:0] rd);
		return {imm, rd, 7'b0110111};
	endfunction

	function automatic logic [31:0] enc_branch(input int off, input logic [4:0] rs2,
		input logic [4:0] rs1, input logic [2:0] funct3);
		logic [12:0] imm;
		imm = off[12:0];
		return {imm[12], imm[10:5], rs2, rs1, funct3, imm[4:1], imm[11], 7'b1100011};
	endfunction

	function automatic logic [31:0] enc_jal(input int off, input logic [4:0] rd);
		logic [20:0] imm;
		imm = off[20:0];
		return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b1101111};
	endfunction

	// Forward jumps of one to four words keep most of the program reachable.
	task automatic build_program();
		int         kind;
		int         room;
		int         off;
		logic [4:0] rd;
		logic [4:0] rs1;
		logic [4:0] rs2;
		for (int i = 0; i < PROG_LEN - 1; i++) begin
			kind = int'($urandom % 11);
			rd   = 5'($urandom % 8);
			rs1  = 5'($urandom % 8);
			rs2  = 5'($urandom % 8);
			room = (PROG_LEN - 1 - i < 4) ? PROG_LEN - 1 - i : 4;
			off  = 4 * (1 + int'($urandom % room));
			case (kind)
				0:       prog[i] = enc_r(7'h00, rs2, rs1, 3'b000, rd);
				1:       prog[i] = enc_r(7'h20, rs2, rs1, 3'b000, rd);
				2:       prog[i] = enc_r(7'h00, rs2, rs1, 3'b111, rd);
				3:       prog[i] = enc_r(7'h00, rs2, rs1, 3'b110, rd);
				4:       prog[i] = enc_r(7'h00, rs2, rs1, 3'b100, rd);
				5, 6:    prog[i] = enc_addi(12'($urandom), rs1, rd);
				7:       prog[i] = enc_lui(20'($urandom), rd);
				8:       prog[i] = enc_branch(off, rs2, rs1, 3'b000);
				9:       prog[i] = enc_branch(off, rs2, rs1, 3'b001);
				default: prog[i] = enc_jal(off, rd);
			endcase
		end
		// Closing self-loop.
		prog[PROG_LEN-1] = enc_jal(0, 5'd1);
	endtask

	initial begin
		rst       = 1'b1;
		load_en   = 1'b0;
		load_addr = '0;
		load_data = '0;
		void'($urandom(32'h52b));
		build_program();
		for (int i = 0; i < PROG_LEN; i++) begin
			@(posedge clk);
			load_en   <= 1'b1;
			load_addr <= i[$clog2(IMEM_DEPTH)-1:0];
			load_data <= prog[i];
		end
		@(posedge clk);
		load_en <= 1'b0;
		repeat (10) @(posedge clk);
		rst <= 1'b0;
	end

	// Compare every retirement against the reference model.
	initial begin : compare_retires
		int          waited;
		logic [31:0] model_pc;
		logic [31:0] model_regs [32];
		logic [31:0] exp_pc;
		logic [4:0]  exp_rd;
		logic [31:0] exp_wdata;
		model_pc = 32'h0;
		for (int r = 0; r < 32; r++)
			model_regs[r] = '0;
		waited = 0;
		while (rst !== 1'b0 && waited < RESET_TIMEOUT) begin
			@(negedge clk);
			waited++;
		end
		assert (rst === 1'b0) else stop_with_failure("Reset was never released.");
		for (int n = 0; n < NUM_RETIRE; n++) begin
			waited = 0;
			@(negedge clk);
			while (retire_valid !== 1'b1 && waited < RETIRE_TIMEOUT) begin
				@(negedge clk);
				waited++;
			end
			assert (retire_valid === 1'b1) else stop_with_failure($sformatf(
				"Retirement %0d never came within %0d cycles.", n, RETIRE_TIMEOUT));
			rv_ref_step(prog[model_pc[7:2]], model_pc, model_regs, exp_pc, exp_rd, exp_wdata);
			assert (retire_pc === exp_pc) else stop_with_failure($sformatf(
				"FAIL retire_pc got %h expected %h", retire_pc, exp_pc));
			assert (retire_rd === exp_rd) else stop_with_failure($sformatf(
				"FAIL retire_rd got %h expected %h at pc %h", retire_rd, exp_rd, exp_pc));
			assert (retire_wdata === exp_wdata) else stop_with_failure($sformatf(
				"FAIL retire_wdata got %h expected %h at pc %h", retire_wdata, exp_wdata,
				exp_pc));
		end
		$display("SIMULATION PASSED");
		$finish;
	end

endmodule

`default_nettype wire

/* rv_core.f */
+incdir+include
hdl/rv_core_pkg.sv
hdl/rv_fetch.sv
hdl/rv_decode.sv
hdl/rv_execute.sv
hdl/rv_result.sv
hdl/rv_imem.sv
hdl/rv_core_top.sv
bench/rv_core_tb.sv

/* Makefile */
# Verilator build and run of the RV32I core testbench.

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build and run the testbench with Verilator"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -Wno-fatal \
		-f rv_core.f --top-module rv_core_tb -Mdir obj_dir
	./obj_dir/Vrv_core_tb

clean:
	rm -rf obj_dir
